// ==== include/periph_consts.svh ====
`ifndef PERIPH_CONSTS_SVH
`define PERIPH_CONSTS_SVH

// number of interval timers in the block
`define PERIPH_NUM_TIMERS 2

// bus address width
`define PERIPH_ADDR_W 4

// address map
// 0..3 timer 0, 4..7 timer 1, 8 irq status, 9..15 unmapped
`define TIMER0_BASE 4'h0
`define TIMER1_BASE 4'h4
`define IRQ_STATUS_ADDR 4'h8

// timer latch value out of reset
`define LATCH_RESET 16'hffff

`endif

// ==== src/periph_pkg.sv ====
`include "periph_consts.svh"

package periph_pkg;

    // one bus byte
    typedef logic [7:0] data_t;

    // latch and counter width
    typedef logic [15:0] count_t;

    // register index inside one timer
    typedef logic [1:0] reg_sel_t;

    // one bit per timer
    typedef logic [`PERIPH_NUM_TIMERS-1:0] irq_vec_t;

    // register access to one block, decoded from the bus
    typedef struct packed {
        logic     wr;
        logic     rd;
        reg_sel_t sel;
        data_t    wdata;
    } reg_acc_t;

    // timer FSM
    // T_DONE is only reached in one-shot mode
    typedef enum logic [1:0] {
        T_IDLE,
        T_RUN,
        T_DONE
    } timer_state_t;

endpackage

// ==== src/bus_ctrl.sv ====
`timescale 1ns/10ps

`include "periph_consts.svh"

module bus_ctrl import periph_pkg::*; (
    input  logic                      clk,
    input  logic                      i_cs,
    input  logic                      i_rwb,
    input  logic [`PERIPH_ADDR_W-1:0] i_addr,
    input  data_t                     i_data,
    input  data_t                     i_timer_rdata [`PERIPH_NUM_TIMERS],
    input  data_t                     i_irq_status,
    output reg_acc_t                  o_timer_acc [`PERIPH_NUM_TIMERS],
    output logic                      o_irq_rd,
    output data_t                     o_data
);

    // each timer occupies four consecutive addresses
    localparam logic [`PERIPH_ADDR_W-1:0] TIMER_BASE [`PERIPH_NUM_TIMERS] = '{
        `TIMER0_BASE,
        `TIMER1_BASE
    };

    logic                          bus_wr;
    logic                          bus_rd;
    logic [`PERIPH_NUM_TIMERS-1:0] timer_hit;
    logic                          irq_hit;
    logic [`PERIPH_NUM_TIMERS:0]   target_strobe;

    assign bus_wr = i_cs & ~i_rwb;
    assign bus_rd = i_cs & i_rwb;

    // match on the upper address bits, the low two pick the register
    always_comb begin
        for (int i = 0; i < `PERIPH_NUM_TIMERS; i++) begin
            timer_hit[i] = (i_addr[`PERIPH_ADDR_W-1:2] == TIMER_BASE[i][`PERIPH_ADDR_W-1:2]);
        end
    end

    assign irq_hit = (i_addr == `IRQ_STATUS_ADDR);

    genvar g;
    generate
        for (g = 0; g < `PERIPH_NUM_TIMERS; g++) begin : g_acc
            assign o_timer_acc[g].wr    = bus_wr & timer_hit[g];
            assign o_timer_acc[g].rd    = bus_rd & timer_hit[g];
            assign o_timer_acc[g].sel   = reg_sel_t'(i_addr[1:0]);
            assign o_timer_acc[g].wdata = i_data;

            assign target_strobe[g] = o_timer_acc[g].wr | o_timer_acc[g].rd;
        end
    endgenerate

    // status register is read only, writes there are dropped
    assign o_irq_rd = bus_rd & irq_hit;
    assign target_strobe[`PERIPH_NUM_TIMERS] = o_irq_rd;

    // read data follows the address with no register stage
    // unmapped addresses fall through to zero
    always_comb begin
        o_data = '0;
        for (int i = 0; i < `PERIPH_NUM_TIMERS; i++) begin
            if (timer_hit[i]) begin
                o_data = i_timer_rdata[i];
            end
        end
        if (irq_hit) begin
            o_data = i_irq_status;
        end
    end

    // the base addresses must never overlap
    a_one_target: assert property (@(posedge clk) $onehot0(target_strobe))
        else $error("bus_ctrl: more than one target strobed, addr %h", i_addr);

endmodule

// ==== src/timer_prescaler.sv ====
`timescale 1ns/10ps

module timer_prescaler import periph_pkg::*; (
    input  logic  clk,
    input  logic  reset,
    input  logic  i_run,
    input  logic  i_restart,
    input  data_t i_divisor,
    output logic  o_tick
);

    count_t pulse_cnt;

    // tick once the upper byte reaches the divisor,
    // so one tick every divisor*256+1 running cycles
    assign o_tick = i_run & (pulse_cnt[15:8] == i_divisor);

    always_ff @(posedge clk) begin
        if (reset) begin
            pulse_cnt <= '0;
        end else if (i_restart) begin
            pulse_cnt <= '0;
        end else if (i_run) begin
            if (o_tick) begin
                pulse_cnt <= '0;
            end else begin
                pulse_cnt <= pulse_cnt + 16'd1;
            end
        end
        // frozen while not running
    end

endmodule

// ==== src/timer.sv ====
`timescale 1ns/10ps

`include "periph_consts.svh"

module timer import periph_pkg::*; (
    input  logic     clk,
    input  logic     reset,
    input  reg_acc_t i_acc,
    output data_t    o_rdata,
    output logic     o_expire
);

    /*
    sel   read           write
    0     counter low    latch low, starts the timer
    1     counter high   latch high
    2     divisor        divisor
    3     status         control
    */

    count_t       latch;
    count_t       counter;
    data_t        divisor;
    data_t        control;
    timer_state_t state;
    timer_state_t state_next;

    logic start;
    logic tick;
    logic hit;
    logic hit_q;
    logic irq_en;
    logic one_shot;

    // control bit 0 enables the interrupt, bit 1 selects one-shot
    assign irq_en   = control[0];
    assign one_shot = control[1];

    assign start = i_acc.wr & (i_acc.sel == 2'd0);

    // hit_q keeps a zero latch in repeat mode from expiring on back to back cycles
    assign hit = (state == T_RUN) & (counter == latch) & ~hit_q;

    assign o_expire = hit & irq_en;

    timer_prescaler u_prescaler (
        .clk       (clk),
        .reset     (reset),
        .i_run     (state == T_RUN),
        .i_restart (start),
        .i_divisor (divisor),
        .o_tick    (tick)
    );

    always_comb begin
        state_next = state;
        case (state)
            T_RUN: begin
                if (hit && one_shot) begin
                    state_next = T_DONE;
                end
            end
            default: begin
            end
        endcase
        // a start from any state runs again
        if (start) begin
            state_next = T_RUN;
        end
    end

    always_ff @(posedge clk) begin
        if (reset) begin
            state   <= T_IDLE;
            hit_q   <= 1'b0;
            counter <= '0;
            latch   <= `LATCH_RESET;
            divisor <= '0;
            control <= '0;
        end else begin
            state <= state_next;
            hit_q <= hit;

            if (start) begin
                counter <= '0;
            end else if (hit) begin
                // one-shot holds the latch value in the counter
                if (!one_shot) begin
                    counter <= '0;
                end
            end else if ((state == T_RUN) && tick && (counter != latch)) begin
                counter <= counter + 16'd1;
            end

            if (i_acc.wr) begin
                case (i_acc.sel)
                    2'd0: latch[7:0]  <= i_acc.wdata;
                    2'd1: latch[15:8] <= i_acc.wdata;
                    2'd2: divisor     <= i_acc.wdata;
                    2'd3: control     <= i_acc.wdata;
                endcase
            end
        end
    end

    always_comb begin
        case (i_acc.sel)
            2'd0: o_rdata = counter[7:0];
            2'd1: o_rdata = counter[15:8];
            2'd2: o_rdata = divisor;
            default: o_rdata = {7'd0, state == T_RUN};
        endcase
    end

    a_expire_pulse: assert property (@(posedge clk) disable iff (reset)
        o_expire |=> !o_expire)
        else $error("timer: expiry held high for two cycles");

endmodule

// ==== src/irq_ctrl.sv ====
`timescale 1ns/10ps

module irq_ctrl import periph_pkg::*; (
    input  logic     clk,
    input  logic     reset,
    input  irq_vec_t i_expire,
    input  logic     i_status_rd,
    output data_t    o_status,
    output logic     o_irqb
);

    irq_vec_t pending;
    irq_vec_t pending_next;
    logic     irqb_q;

    // a status read clears at the end of the cycle,
    // an expiry in that same cycle still lands
    always_comb begin
        pending_next = pending;
        if (i_status_rd) begin
            pending_next = '0;
        end
        pending_next = pending_next | i_expire;
    end

    always_ff @(posedge clk) begin
        if (reset) begin
            pending <= '0;
            irqb_q  <= 1'b1;
        end else begin
            pending <= pending_next;
            // active low, any pending bit pulls it down
            irqb_q  <= ~|pending_next;
        end
    end

    assign o_status = data_t'(pending);
    assign o_irqb   = irqb_q;

    a_irqb_match: assert property (@(posedge clk) disable iff (reset)
        o_irqb == ~|pending)
        else $error("irq_ctrl: o_irqb %b disagrees with pending %b", o_irqb, pending);

endmodule

// ==== src/periph_top.sv ====
`timescale 1ns/10ps

`include "periph_consts.svh"

module periph_top import periph_pkg::*; (
    input  logic                      clk,
    input  logic                      reset,
    input  logic                      i_cs,
    input  logic                      i_rwb,
    input  logic [`PERIPH_ADDR_W-1:0] i_addr,
    input  data_t                     i_data,
    output data_t                     o_data,
    output logic                      o_irqb
);

    reg_acc_t timer_acc   [`PERIPH_NUM_TIMERS];
    data_t    timer_rdata [`PERIPH_NUM_TIMERS];
    irq_vec_t timer_expire;
    logic     irq_rd;
    data_t    irq_status;

    bus_ctrl u_bus_ctrl (
        .clk           (clk),
        .i_cs          (i_cs),
        .i_rwb         (i_rwb),
        .i_addr        (i_addr),
        .i_data        (i_data),
        .i_timer_rdata (timer_rdata),
        .i_irq_status  (irq_status),
        .o_timer_acc   (timer_acc),
        .o_irq_rd      (irq_rd),
        .o_data        (o_data)
    );

    // one timer per interrupt bit
    genvar g;
    generate
        for (g = 0; g < `PERIPH_NUM_TIMERS; g++) begin : g_timer
            timer u_timer (
                .clk      (clk),
                .reset    (reset),
                .i_acc    (timer_acc[g]),
                .o_rdata  (timer_rdata[g]),
                .o_expire (timer_expire[g])
            );
        end
    endgenerate

    irq_ctrl u_irq_ctrl (
        .clk         (clk),
        .reset       (reset),
        .i_expire    (timer_expire),
        .i_status_rd (irq_rd),
        .o_status    (irq_status),
        .o_irqb      (o_irqb)
    );

endmodule

// ==== verif/periph_tb.sv ====
`timescale 1ns/10ps

`include "periph_consts.svh"

module periph_tb import periph_pkg::*; ();

    logic                      clk = 1'b0;
    logic                      reset;
    logic                      i_cs;
    logic                      i_rwb;
    logic [`PERIPH_ADDR_W-1:0] i_addr;
    data_t                     i_data;
    data_t                     o_data;
    logic                      o_irqb;

    integer seed = 32'hf01c3090;

    int   errors = 0;
    int   base_errors = 0;
    int   tests_passed = 0;
    int   tests_failed = 0;
    logic expect_quiet = 1'b0;

    periph_top dut (
        .clk    (clk),
        .reset  (reset),
        .i_cs   (i_cs),
        .i_rwb  (i_rwb),
        .i_addr (i_addr),
        .i_data (i_data),
        .o_data (o_data),
        .o_irqb (o_irqb)
    );

    always #20 clk = ~clk;

    // addresses above the status register read as zero
    a_unmapped_zero: assert property (@(posedge clk) disable iff (reset)
        (i_cs && i_rwb && (i_addr > `IRQ_STATUS_ADDR)) |-> (o_data == 8'h00))
        else begin
            $display("FAIL at %0t: unmapped address %h read %h", $time, i_addr, o_data);
            errors++;
        end

    // held high while the only running timer has its interrupt disabled
    a_quiet_irq: assert property (@(posedge clk) disable iff (reset || !expect_quiet) o_irqb)
        else begin
            $display("FAIL at %0t: o_irqb went low with interrupts disabled", $time);
            errors++;
        end

    function automatic logic [`PERIPH_ADDR_W-1:0] reg_addr(input int idx, input reg_sel_t sel);
        logic [`PERIPH_ADDR_W-1:0] base;
        base = (idx == 0) ? `TIMER0_BASE : `TIMER1_BASE;
        return base + {2'b00, sel};
    endfunction

    function automatic data_t draw_latch();
        return data_t'(1 + ($unsigned($random(seed)) % 40));
    endfunction

    function automatic data_t draw_divisor();
        return data_t'($unsigned($random(seed)) % 2);
    endfunction

    // starts on a falling edge, returns on the next one with the bus idle
    task automatic bus_write(input logic [`PERIPH_ADDR_W-1:0] addr, input data_t data);
        i_cs   = 1'b1;
        i_rwb  = 1'b0;
        i_addr = addr;
        i_data = data;
        @(negedge clk);
        i_cs  = 1'b0;
        i_rwb = 1'b1;
    endtask

    task automatic bus_read(input logic [`PERIPH_ADDR_W-1:0] addr, output data_t data);
        i_cs   = 1'b1;
        i_rwb  = 1'b1;
        i_addr = addr;
        // sample in the low phase, clear of both edges
        #5;
        data = o_data;
        @(negedge clk);
        i_cs = 1'b0;
    endtask

    task automatic check_equal(input string what, input data_t got, input data_t exp);
        assert (got === exp) else begin
            $display("FAIL at %0t: %s is %h, expected %h", $time, what, got, exp);
            errors++;
        end
    endtask

    task automatic read_check(input string what, input logic [`PERIPH_ADDR_W-1:0] addr,
                              input data_t exp);
        data_t got;
        bus_read(addr, got);
        check_equal(what, got, exp);
    endtask

    task automatic read_counter(input int idx, output count_t value);
        data_t lo;
        data_t hi;
        bus_read(reg_addr(idx, 2'd0), lo);
        bus_read(reg_addr(idx, 2'd1), hi);
        value = {hi, lo};
    endtask

    task automatic start_timer(input int idx, input data_t control, input data_t divisor,
                               input count_t latch);
        bus_write(reg_addr(idx, 2'd3), control);
        bus_write(reg_addr(idx, 2'd2), divisor);
        bus_write(reg_addr(idx, 2'd1), latch[15:8]);
        // low latch byte last, it starts the count
        bus_write(reg_addr(idx, 2'd0), latch[7:0]);
    endtask

    task automatic wait_irq_low(input int max_cycles);
        int n;
        n = 0;
        while (o_irqb && n < max_cycles) begin
            @(negedge clk);
            n++;
        end
        if (o_irqb) begin
            $display("timeout: o_irqb did not go low within %0d cycles", max_cycles);
            errors++;
        end
    endtask

    task automatic wait_timer_done(input int idx, input int max_cycles);
        data_t status;
        int    n;
        n = 0;
        bus_read(reg_addr(idx, 2'd3), status);
        while (status[0] && n < max_cycles) begin
            bus_read(reg_addr(idx, 2'd3), status);
            n++;
        end
        if (status[0]) begin
            $display("timeout: timer %0d still running after %0d cycles", idx, max_cycles);
            errors++;
        end
    endtask

    // one-shot with no interrupt, then wait for it to leave T_RUN
    task automatic stop_timer(input int idx);
        bus_write(reg_addr(idx, 2'd3), 8'h02);
        wait_timer_done(idx, 12000);
    endtask

    task automatic report_test(input string name);
        if (errors == base_errors) begin
            tests_passed++;
            $display("test %s: ok", name);
        end else begin
            tests_failed++;
            $display("test %s: %0d errors", name, errors - base_errors);
        end
        base_errors = errors;
    endtask

    initial begin : main
        data_t  divs [`PERIPH_NUM_TIMERS];
        data_t  lat0;
        data_t  lat1;
        data_t  div;
        data_t  prev;
        data_t  got;
        count_t cnt;
        int     limit;
        int     period;
        logic   wrapped;

        reset  = 1'b1;
        i_cs   = 1'b0;
        i_rwb  = 1'b1;
        i_addr = '0;
        i_data = '0;
        repeat (4) @(negedge clk);
        reset = 1'b0;
        @(negedge clk);

        check_equal("o_irqb", {7'd0, o_irqb}, 8'h01);
        for (int i = 0; i < `PERIPH_NUM_TIMERS; i++) begin
            read_check("counter low", reg_addr(i, 2'd0), 8'h00);
            read_check("counter high", reg_addr(i, 2'd1), 8'h00);
            read_check("divisor", reg_addr(i, 2'd2), 8'h00);
            read_check("timer status", reg_addr(i, 2'd3), 8'h00);
        end
        read_check("irq status", `IRQ_STATUS_ADDR, 8'h00);
        report_test("1 reset values");

        for (int i = 0; i < `PERIPH_NUM_TIMERS; i++) begin
            divs[i] = data_t'($random(seed));
            bus_write(reg_addr(i, 2'd2), divs[i]);
            read_check("divisor readback", reg_addr(i, 2'd2), divs[i]);
        end
        for (int a = 9; a < 16; a++) begin
            bus_write(a[`PERIPH_ADDR_W-1:0], data_t'($random(seed)));
            read_check("unmapped read", a[`PERIPH_ADDR_W-1:0], 8'h00);
        end
        for (int i = 0; i < `PERIPH_NUM_TIMERS; i++) begin
            read_check("divisor after unmapped writes", reg_addr(i, 2'd2), divs[i]);
        end
        read_check("irq status", `IRQ_STATUS_ADDR, 8'h00);
        report_test("2 register readback");

        lat0 = draw_latch();
        start_timer(0, 8'h03, 8'h00, {8'h00, lat0});
        wait_irq_low(int'(lat0) + 20);
        read_counter(0, cnt);
        assert (cnt == {8'h00, lat0}) else begin
            $display("FAIL at %0t: one-shot counter %0d, latch %0d", $time, cnt, lat0);
            errors++;
        end
        read_check("timer 0 status", reg_addr(0, 2'd3), 8'h00);
        read_check("irq status", `IRQ_STATUS_ADDR, 8'h01);
        check_equal("o_irqb after clear", {7'd0, o_irqb}, 8'h01);
        report_test("3 one-shot with interrupt");

        lat1 = draw_latch();
        expect_quiet = 1'b1;
        start_timer(1, 8'h00, 8'h00, {8'h00, lat1});
        prev    = 8'h00;
        wrapped = 1'b0;
        limit   = 4 * (int'(lat1) + 2) + 20;
        for (int n = 0; n < limit && !wrapped; n++) begin
            bus_read(reg_addr(1, 2'd0), got);
            assert (got <= lat1) else begin
                $display("FAIL at %0t: repeat counter %0d above latch %0d", $time, got, lat1);
                errors++;
            end
            if (got < prev) begin
                wrapped = 1'b1;
            end
            prev = got;
        end
        if (!wrapped) begin
            $display("timeout: timer 1 counter never wrapped within %0d reads", limit);
            errors++;
        end
        check_equal("o_irqb in repeat mode", {7'd0, o_irqb}, 8'h01);
        expect_quiet = 1'b0;
        report_test("4 repeat without interrupt");

        stop_timer(0);
        stop_timer(1);
        read_check("irq status before start", `IRQ_STATUS_ADDR, 8'h00);
        div    = draw_divisor();
        lat0   = draw_latch();
        lat1   = draw_latch();
        period = int'(div) * 256 + 1;
        limit  = 42 * period + 20;
        start_timer(0, 8'h03, div, {8'h00, lat0});
        start_timer(1, 8'h03, div, {8'h00, lat1});
        wait_irq_low(limit);
        wait_timer_done(0, limit);
        wait_timer_done(1, limit);
        read_check("irq status", `IRQ_STATUS_ADDR, 8'h03);
        check_equal("o_irqb after status read", {7'd0, o_irqb}, 8'h01);
        read_check("irq status second read", `IRQ_STATUS_ADDR, 8'h00);
        report_test("5 interrupt status and clear");

        // large latch so the count cannot wrap during the wait
        period = 1 * 256 + 1;
        start_timer(0, 8'h00, 8'h01, {8'hff, draw_latch()});
        repeat (1000) @(negedge clk);
        read_counter(0, cnt);
        assert (int'(cnt) <= 1000 / period + 1 && int'(cnt) >= 1000 / period - 1) else begin
            $display("FAIL at %0t: divisor 1 counter %0d after 1000 cycles", $time, cnt);
            errors++;
        end
        report_test("6 divisor scaling");

        $display("tests passed %0d, failed %0d", tests_passed, tests_failed);
        if (errors == 0) begin
            $display("Simulation passed");
        end else begin
            $display("Simulation failed");
        end
        $finish;
    end

endmodule

// ==== filelist.f ====
+incdir+include
src/periph_pkg.sv
src/bus_ctrl.sv
src/timer_prescaler.sv
src/timer.sv
src/irq_ctrl.sv
src/periph_top.sv
verif/periph_tb.sv

// ==== Makefile ====
TOP = periph_tb

.PHONY: all build run lint clean

all: run

build:
	verilator --binary --timing --assert -j 0 --top-module $(TOP) -f filelist.f

run: build
	./obj_dir/V$(TOP) > sim.log 2>&1 || true
	@cat sim.log
	@if grep -q "Simulation failed" sim.log; then echo "run failed"; exit 1; fi
	@if ! grep -q "Simulation passed" sim.log; then echo "run ended without a result"; exit 1; fi

lint:
	verilator --lint-only --timing --assert --top-module $(TOP) -f filelist.f

clean:
	rm -rf obj_dir sim.log
